// ==== include/mpeg_defines.svh ====
// start code values for the MPEG-1 system stream
// pack header length, stuffing byte and timestamp field lengths
`ifndef MPEG_DEFINES_SVH
`define MPEG_DEFINES_SVH

// start code values following the 00 00 01 prefix
`define MPEG_END_CODE           8'hB9
`define MPEG_PACK_CODE          8'hBA
`define MPEG_SYSHDR_CODE        8'hBB
`define MPEG_FIRST_STREAM_CODE  8'hBC
`define MPEG_PADDING_CODE       8'hBE
`define MPEG_PRIVATE2_CODE      8'hBF

`define MPEG_PACK_BYTES         8   // pack header body after the code

// packet header fields
`define MPEG_STUFF_BYTE         8'hFF
`define MPEG_NO_STAMP_BYTE      8'h0F
`define MPEG_PTS_BYTES          5   // 0010 pattern
`define MPEG_PTS_DTS_BYTES      10  // 0011 pattern

`endif

// ==== logic/bit_deserializer.sv ====
// serial to byte converter, LSB first
// byte strobe pulses once every eighth enabled bit
module bit_deserializer (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           en,
	input  logic           bit_in,
	output mpeg_pkg::byte_t byte_data,
	output logic           byte_strobe
);

	logic [6:0] shift_q;  // first seven bits of the byte
	logic [2:0] bit_cnt;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			bit_cnt     <= 3'd0;
			byte_strobe <= 1'b0;
		end
		else
		begin
			byte_strobe <= en && (bit_cnt == 3'd7);
			if (en)
				bit_cnt <= bit_cnt + 3'd1;  // wraps to zero after bit 7
		end
	end

	// data path, no reset
	always_ff @(posedge clk)
	begin
		if (en)
		begin
			shift_q <= {bit_in, shift_q[6:1]};
			if (bit_cnt == 3'd7)
				byte_data <= {bit_in, shift_q};
		end
	end

endmodule

// ==== logic/mpeg_pkg.sv ====
// vector types for the system stream parser
// state enums for the stream sequencer and the packet parser
package mpeg_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [7:0]  stream_id_t;
	typedef logic [15:0] length_t;
	typedef logic [32:0] scr_t;       // 90 kHz system clock reference
	typedef logic [21:0] mux_rate_t;  // units of 50 bytes/s

	typedef enum logic [1:0] {
		seq_hunt,
		seq_pack_header,
		seq_packet,
		seq_stream_done
	} seq_state_t;

	typedef enum logic [2:0] {
		pkt_len_hi,
		pkt_len_lo,
		pkt_header,   // stuffing, STD and timestamp lead byte
		pkt_std_lo,
		pkt_stamp,
		pkt_payload,
		pkt_skip
	} pkt_state_t;

endpackage

// ==== logic/pack_header_parser.sv ====
// pack header decoder
// collects the 8 header bytes and extracts SCR and mux rate
`include "mpeg_defines.svh"

module pack_header_parser (
	input  logic               clk,
	input  logic               rst_n,
	input  mpeg_pkg::byte_t    byte_data,
	input  logic               byte_strobe,
	input  logic               start,
	output logic               done,
	output mpeg_pkg::scr_t     scr,
	output mpeg_pkg::mux_rate_t mux_rate
);

	logic        active;
	logic [2:0]  byte_cnt;
	logic [55:0] hdr_q;    // bytes 0 to 6, byte 0 at the top
	logic [63:0] hdr;

	assign hdr = {hdr_q, byte_data};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			active   <= 1'b0;
			byte_cnt <= 3'd0;
			done     <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				active   <= 1'b1;
				byte_cnt <= 3'd0;
			end
			else if (active && byte_strobe)
			begin
				byte_cnt <= byte_cnt + 3'd1;
				if (byte_cnt == 3'(`MPEG_PACK_BYTES - 1))
				begin
					active <= 1'b0;
					done   <= 1'b1;
				end
			end
		end
	end

	// marker bits dropped during extraction
	always_ff @(posedge clk)
	begin
		if (active && byte_strobe)
		begin
			hdr_q <= hdr[55:0];
			if (byte_cnt == 3'(`MPEG_PACK_BYTES - 1))
			begin
				scr      <= {hdr[59:57], hdr[55:48], hdr[47:41], hdr[39:32], hdr[31:25]};
				mux_rate <= {hdr[22:16], hdr[15:8], hdr[7:1]};
			end
		end
	end

endmodule

// ==== logic/packet_parser.sv ====
// packet body parser
// skips length, stuffing, STD and timestamp fields, emits payload bytes
// system header and padding bodies are skipped whole
`include "mpeg_defines.svh"

module packet_parser (
	input  logic                 clk,
	input  logic                 rst_n,
	input  mpeg_pkg::byte_t      byte_data,
	input  logic                 byte_strobe,
	input  logic                 start,
	input  mpeg_pkg::stream_id_t packet_id,
	output logic                 done,
	output mpeg_pkg::byte_t      payload_data,
	output logic                 payload_valid,
	output mpeg_pkg::stream_id_t payload_id
);

	mpeg_pkg::pkt_state_t state;
	mpeg_pkg::length_t    remaining;   // body bytes still to come
	mpeg_pkg::length_t    length;
	mpeg_pkg::byte_t      len_hi_q;
	logic                 active;
	logic [3:0]           stamp_cnt;
	logic                 last_byte;
	logic                 skip_id;

	assign length    = {len_hi_q, byte_data};
	assign last_byte = (remaining == 16'd1);
	assign skip_id   = (payload_id == `MPEG_SYSHDR_CODE) || (payload_id == `MPEG_PADDING_CODE);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			active        <= 1'b0;
			state         <= mpeg_pkg::pkt_len_hi;
			remaining     <= '0;
			stamp_cnt     <= 4'd0;
			done          <= 1'b0;
			payload_valid <= 1'b0;
		end
		else
		begin
			done          <= 1'b0;
			payload_valid <= 1'b0;
			if (start)
			begin
				active <= 1'b1;
				state  <= mpeg_pkg::pkt_len_hi;
			end
			else if (active && byte_strobe)
			begin
				if (state != mpeg_pkg::pkt_len_hi && state != mpeg_pkg::pkt_len_lo)
				begin
					remaining <= remaining - 16'd1;
					if (last_byte)
					begin
						active <= 1'b0;  // count exhausted in any state
						done   <= 1'b1;
					end
				end
				case (state)
					mpeg_pkg::pkt_len_hi: state <= mpeg_pkg::pkt_len_lo;
					mpeg_pkg::pkt_len_lo:
					begin
						remaining <= length;
						if (length == 16'd0)
						begin
							active <= 1'b0;
							done   <= 1'b1;
						end
						else if (skip_id)
							state <= mpeg_pkg::pkt_skip;
						else if (payload_id == `MPEG_PRIVATE2_CODE)
							state <= mpeg_pkg::pkt_payload;  // no header extension
						else
							state <= mpeg_pkg::pkt_header;
					end
					mpeg_pkg::pkt_header:
					begin
						if (byte_data == `MPEG_STUFF_BYTE)
							state <= mpeg_pkg::pkt_header;
						else if (byte_data[7:6] == 2'b01)
							state <= mpeg_pkg::pkt_std_lo;
						else if (byte_data[7:4] == 4'b0010)
						begin
							stamp_cnt <= 4'(`MPEG_PTS_BYTES - 1);
							state     <= mpeg_pkg::pkt_stamp;
						end
						else if (byte_data[7:4] == 4'b0011)
						begin
							stamp_cnt <= 4'(`MPEG_PTS_DTS_BYTES - 1);
							state     <= mpeg_pkg::pkt_stamp;
						end
						else
						begin
							state <= mpeg_pkg::pkt_payload;
							// unknown lead byte is already data
							payload_valid <= (byte_data != `MPEG_NO_STAMP_BYTE);
						end
					end
					mpeg_pkg::pkt_std_lo: state <= mpeg_pkg::pkt_header;  // timestamp next
					mpeg_pkg::pkt_stamp:
					begin
						stamp_cnt <= stamp_cnt - 4'd1;
						if (stamp_cnt == 4'd1)
							state <= mpeg_pkg::pkt_payload;
					end
					mpeg_pkg::pkt_payload: payload_valid <= 1'b1;
					default: state <= mpeg_pkg::pkt_skip;
				endcase
			end
		end
	end

	// payload path, no reset
	always_ff @(posedge clk)
	begin
		if (start)
			payload_id <= packet_id;  // held for the whole packet
		if (active && byte_strobe)
		begin
			payload_data <= byte_data;
			if (state == mpeg_pkg::pkt_len_hi)
				len_hi_q <= byte_data;
		end
	end

endmodule

// ==== logic/start_code_detector.sv ====
// start code prefix search for 00 00 01
// reports the code byte that follows the prefix
module start_code_detector (
	input  logic                clk,
	input  logic                rst_n,
	input  mpeg_pkg::byte_t     byte_data,
	input  logic                byte_strobe,
	input  logic                hunt,
	output logic                code_strobe,
	output mpeg_pkg::stream_id_t code_value
);

	typedef enum logic [1:0] {
		match_idle,
		match_zero,
		match_zero_zero,
		match_prefix
	} match_state_t;

	match_state_t match_state;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			match_state <= match_idle;
			code_strobe <= 1'b0;
		end
		else
		begin
			code_strobe <= 1'b0;
			if (!hunt)
				match_state <= match_idle;
			else if (byte_strobe)
			begin
				case (match_state)
					match_idle: match_state <= (byte_data == 8'h00) ? match_zero : match_idle;
					match_zero: match_state <= (byte_data == 8'h00) ? match_zero_zero : match_idle;
					match_zero_zero:
					begin
						if (byte_data == 8'h01)
							match_state <= match_prefix;
						else if (byte_data != 8'h00)
							match_state <= match_idle;  // extra zeros stay here
					end
					default:
					begin
						code_strobe <= 1'b1;  // byte after prefix is the code
						match_state <= match_idle;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (hunt && byte_strobe && match_state == match_prefix)
			code_value <= byte_data;
	end

endmodule

// ==== logic/system_stream_parser.sv ====
// MPEG-1 system stream parser top level
// stream sequencer plus deserializer, start code detector and parsers
`include "mpeg_defines.svh"

module system_stream_parser (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 en,
	input  logic                 bit_in,
	output logic                 pack_valid,
	output mpeg_pkg::scr_t       scr,
	output mpeg_pkg::mux_rate_t  mux_rate,
	output mpeg_pkg::byte_t      payload_data,
	output logic                 payload_valid,
	output mpeg_pkg::stream_id_t payload_id,
	output logic                 stream_end
);

	mpeg_pkg::seq_state_t seq_state;
	mpeg_pkg::byte_t      byte_data;
	mpeg_pkg::stream_id_t code_value;
	mpeg_pkg::stream_id_t packet_id;
	logic                 byte_strobe;
	logic                 code_strobe;
	logic                 hunt;
	logic                 pack_start;
	logic                 pack_done;
	logic                 packet_start;
	logic                 packet_done;

	assign hunt       = (seq_state == mpeg_pkg::seq_hunt);
	assign stream_end = (seq_state == mpeg_pkg::seq_stream_done);
	assign pack_valid = pack_done;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			seq_state    <= mpeg_pkg::seq_hunt;
			pack_start   <= 1'b0;
			packet_start <= 1'b0;
		end
		else
		begin
			pack_start   <= 1'b0;
			packet_start <= 1'b0;
			case (seq_state)
				mpeg_pkg::seq_hunt:
				begin
					if (code_strobe && code_value == `MPEG_PACK_CODE)
					begin
						seq_state  <= mpeg_pkg::seq_pack_header;
						pack_start <= 1'b1;
					end
					else if (code_strobe && code_value == `MPEG_END_CODE)
						seq_state <= mpeg_pkg::seq_stream_done;
					else if (code_strobe && (code_value >= `MPEG_FIRST_STREAM_CODE ||
							code_value == `MPEG_SYSHDR_CODE))
					begin
						seq_state    <= mpeg_pkg::seq_packet;
						packet_start <= 1'b1;
					end
					// lower codes are ignored
				end
				mpeg_pkg::seq_pack_header: if (pack_done) seq_state <= mpeg_pkg::seq_hunt;
				mpeg_pkg::seq_packet: if (packet_done) seq_state <= mpeg_pkg::seq_hunt;
				default: seq_state <= mpeg_pkg::seq_stream_done;  // held until reset
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (hunt && code_strobe)
			packet_id <= code_value;
	end

	bit_deserializer u_deser (.clk, .rst_n, .en, .bit_in, .byte_data, .byte_strobe);

	start_code_detector u_start (.clk, .rst_n, .byte_data, .byte_strobe, .hunt,
		.code_strobe, .code_value);

	pack_header_parser u_pack (.clk, .rst_n, .byte_data, .byte_strobe, .start(pack_start),
		.done(pack_done), .scr, .mux_rate);

	packet_parser u_packet (.clk, .rst_n, .byte_data, .byte_strobe, .start(packet_start),
		.packet_id, .done(packet_done), .payload_data, .payload_valid, .payload_id);

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_system_stream_parser -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
	exit 0
else
	exit 1
fi

// ==== sources.f ====
+incdir+include
logic/mpeg_pkg.sv
logic/bit_deserializer.sv
logic/start_code_detector.sv
logic/pack_header_parser.sv
logic/packet_parser.sv
logic/system_stream_parser.sv
testbench/tb_system_stream_parser.sv

// ==== testbench/tb_system_stream_parser.sv ====
// testbench for the system stream parser
// directed tests, stream building tasks, payload and pack monitor
// value checker, clock, reset and cycle limit
`include "mpeg_defines.svh"

module tb_system_stream_parser;

	// bytes per test: pack 12, packets 53, private 11, skipped 41, gaps 32, end 25
	localparam int TOTAL_BITS     = 8 * (12 + 53 + 11 + 41 + 32 + 25);
	localparam int TIMEOUT_CYCLES = 3 * TOTAL_BITS + 200;

	logic                 clk;
	logic                 rst_n;
	logic                 en;
	logic                 bit_in;
	logic                 pack_valid;
	mpeg_pkg::scr_t       scr;
	mpeg_pkg::mux_rate_t  mux_rate;
	mpeg_pkg::byte_t      payload_data;
	logic                 payload_valid;
	mpeg_pkg::stream_id_t payload_id;
	logic                 stream_end;

	mpeg_pkg::byte_t      hdr_bytes[$];  // packet header fields after the length
	mpeg_pkg::byte_t      pay_bytes[$];
	mpeg_pkg::byte_t      exp_data[$];
	mpeg_pkg::stream_id_t exp_id[$];
	mpeg_pkg::byte_t      got_data[$];
	mpeg_pkg::stream_id_t got_id[$];
	mpeg_pkg::scr_t       got_scr;
	mpeg_pkg::mux_rate_t  got_mux;
	int                   pack_count;
	int                   error_count;
	int                   check_count;
	int                   test_count;
	int                   cycle_count;
	logic                 gaps_on;

	system_stream_parser uut (.clk, .rst_n, .en, .bit_in, .pack_valid, .scr, .mux_rate,
		.payload_data, .payload_valid, .payload_id, .stream_end);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// outputs are stable at the falling edge
	always @(negedge clk)
	begin
		if (payload_valid)
		begin
			got_data.push_back(payload_data);
			got_id.push_back(payload_id);
		end
		if (pack_valid)
		begin
			pack_count++;
			got_scr = scr;
			got_mux = mux_rate;
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("run timed out after %0d cycles", cycle_count);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task check(input string name, input logic [63:0] got, input logic [63:0] exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task send_bit(input logic b);
		int gap;
		gap = gaps_on ? int'($urandom % 4) : 0;
		repeat (gap)
		begin
			@(posedge clk);
			#2 en = 1'b0;
		end
		@(posedge clk);
		#2;
		en     = 1'b1;
		bit_in = b;
	endtask

	task send_byte(input mpeg_pkg::byte_t b);
		for (int i = 0; i < 8; i++)
			send_bit(b[i]);  // LSB first
	endtask

	task idle_bus;
		@(posedge clk);  // last bit sampled here
		#2 en = 1'b0;
	endtask

	task send_start(input mpeg_pkg::stream_id_t code);
		send_byte(8'h00);
		send_byte(8'h00);
		send_byte(8'h01);
		send_byte(code);
	endtask

	task send_pack(input mpeg_pkg::scr_t s, input mpeg_pkg::mux_rate_t m);
		send_start(`MPEG_PACK_CODE);
		send_byte({4'b0010, s[32:30], 1'b1});
		send_byte(s[29:22]);
		send_byte({s[21:15], 1'b1});
		send_byte(s[14:7]);
		send_byte({s[6:0], 1'b1});
		send_byte({1'b1, m[21:15]});
		send_byte(m[14:7]);
		send_byte({m[6:0], 1'b1});
	endtask

	// length covers header fields and payload
	task send_packet(input mpeg_pkg::stream_id_t id);
		mpeg_pkg::length_t len;
		len = 16'(hdr_bytes.size() + pay_bytes.size());
		send_start(id);
		send_byte(len[15:8]);
		send_byte(len[7:0]);
		foreach (hdr_bytes[i])
			send_byte(hdr_bytes[i]);
		foreach (pay_bytes[i])
			send_byte(pay_bytes[i]);
	endtask

	task expect_payload(input mpeg_pkg::stream_id_t id);
		foreach (pay_bytes[i])
		begin
			exp_data.push_back(pay_bytes[i]);
			exp_id.push_back(id);
		end
	endtask

	task clear_queues;
		exp_data.delete();
		exp_id.delete();
		got_data.delete();
		got_id.delete();
		hdr_bytes.delete();
	endtask

	task wait_for_payload(input int n);
		while (got_data.size() < n)
			@(negedge clk);
		repeat (4) @(negedge clk);  // room for extra bytes to show up
	endtask

	task wait_for_pack(input int n);
		while (pack_count < n)
			@(negedge clk);
		repeat (4) @(negedge clk);
	endtask

	task compare_payload;
		int n;
		n = (got_data.size() < exp_data.size()) ? got_data.size() : exp_data.size();
		check("payload count", 64'(got_data.size()), 64'(exp_data.size()));
		for (int i = 0; i < n; i++)
		begin
			check("payload_data", 64'(got_data[i]), 64'(exp_data[i]));
			check("payload_id", 64'(got_id[i]), 64'(exp_id[i]));
		end
	endtask

	task finish_test(input string name, input int errs_before);
		test_count++;
		$display("test %s: %0d mismatches", name, error_count - errs_before);
	endtask

	task test_pack_header;
		int errs_before;
		int pack_base;
		errs_before = error_count;
		pack_base   = pack_count;
		send_pack(33'h1_2345_6789, 22'h2_ABCD);
		idle_bus;
		wait_for_pack(pack_base + 1);
		check("pack count", 64'(pack_count), 64'(pack_base + 1));
		check("scr", 64'(got_scr), 64'(33'h1_2345_6789));
		check("mux_rate", 64'(got_mux), 64'(22'h2_ABCD));
		finish_test("pack_header", errs_before);
	endtask

	task test_packets;
		int errs_before;
		errs_before = error_count;
		clear_queues;
		// stuffing, STD field, PTS
		hdr_bytes = '{8'hFF, 8'hFF, 8'h40, 8'h20, 8'h21, 8'h00, 8'h01, 8'h00, 8'h01};
		pay_bytes = '{8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 8'h66};
		expect_payload(8'hE0);
		send_packet(8'hE0);
		hdr_bytes = '{8'h31, 8'h00, 8'h01, 8'h00, 8'h01, 8'h11, 8'h00, 8'h01, 8'h00, 8'h01};
		pay_bytes = '{8'hA0, 8'hA1, 8'hA2, 8'hA3, 8'hA4};
		expect_payload(8'hC0);
		send_packet(8'hC0);
		hdr_bytes = '{`MPEG_NO_STAMP_BYTE};
		pay_bytes = '{8'h0F, 8'h70, 8'h71, 8'h72};
		expect_payload(8'hE1);
		send_packet(8'hE1);
		idle_bus;
		wait_for_payload(exp_data.size());
		compare_payload;
		finish_test("packets", errs_before);
	endtask

	task test_private_stream;
		int errs_before;
		errs_before = error_count;
		clear_queues;
		pay_bytes = '{8'hFF, 8'hFF, 8'h12, 8'h34, 8'h56};  // whole body is data
		expect_payload(`MPEG_PRIVATE2_CODE);
		send_packet(`MPEG_PRIVATE2_CODE);
		idle_bus;
		wait_for_payload(exp_data.size());
		compare_payload;
		finish_test("private_stream_2", errs_before);
	endtask

	task test_skipped_bodies;
		int errs_before;
		int pack_base;
		errs_before = error_count;
		pack_base   = pack_count;
		clear_queues;
		pay_bytes = '{8'h80, 8'h01, 8'h23, 8'h04, 8'hE1, 8'hFF};
		send_packet(`MPEG_SYSHDR_CODE);
		pay_bytes = '{8'hFF, 8'hFF, 8'hFF, 8'hFF};
		send_packet(`MPEG_PADDING_CODE);
		// start code inside payload is plain data, a full pack body follows it
		hdr_bytes = '{`MPEG_NO_STAMP_BYTE};
		pay_bytes = '{8'h00, 8'h00, 8'h01, `MPEG_PACK_CODE, 8'h44, 8'h21,
			8'h43, 8'h65, 8'h87, 8'hA9, 8'hCB, 8'hED};
		expect_payload(8'hE0);
		send_packet(8'hE0);
		idle_bus;
		wait_for_payload(exp_data.size());
		compare_payload;
		check("pack count", 64'(pack_count), 64'(pack_base));
		finish_test("skipped_bodies", errs_before);
	endtask

	task test_en_gaps;
		int errs_before;
		errs_before = error_count;
		clear_queues;
		hdr_bytes = '{8'hFF, 8'h21, 8'h00, 8'h03, 8'h00, 8'h05};
		pay_bytes = '{8'h5A, 8'hA5, 8'h3C, 8'hC3};
		expect_payload(8'hE2);
		send_packet(8'hE2);
		gaps_on = 1'b1;
		expect_payload(8'hE2);
		send_packet(8'hE2);
		gaps_on = 1'b0;
		idle_bus;
		wait_for_payload(exp_data.size());
		compare_payload;
		finish_test("en_gaps", errs_before);
	endtask

	task test_end_code;
		int errs_before;
		int pack_base;
		errs_before = error_count;
		pack_base   = pack_count;
		clear_queues;
		send_start(`MPEG_END_CODE);
		idle_bus;
		while (!stream_end)
			@(negedge clk);
		send_pack(33'h0_0000_1234, 22'h0_0100);
		hdr_bytes = '{`MPEG_NO_STAMP_BYTE};
		pay_bytes = '{8'h99, 8'h98};
		send_packet(8'hE0);
		idle_bus;
		wait_for_payload(0);
		compare_payload;
		check("pack count", 64'(pack_count), 64'(pack_base));
		check("stream_end", 64'(stream_end), 64'(1'b1));
		finish_test("end_code", errs_before);
	endtask

	initial
	begin
		rst_n       = 1'b0;
		en          = 1'b0;
		bit_in      = 1'b0;
		gaps_on     = 1'b0;
		pack_count  = 0;
		error_count = 0;
		check_count = 0;
		test_count  = 0;
		cycle_count = 0;
		void'($urandom(17916));
		repeat (5) @(posedge clk);
		#2 rst_n = 1'b1;

		test_pack_header;
		test_packets;
		test_private_stream;
		test_skipped_bodies;
		test_en_gaps;
		test_end_code;  // last, stream stays ended

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		if (error_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
